//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_im2col_spc
FILELIST := im2col_spc.f

BIN  := obj_dir/V$(TOP)
LOG  := sim.log
SRCS := $(filter %.sv,$(shell cat $(FILELIST))) $(wildcard *.svh)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- im2col_ch_tracker.sv
// DMA channel tracker: busy and configured bits, lowest free enabled channel pick.
`include "im2col_settings.svh"

module im2col_ch_tracker (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          start_i,
  input  logic [`IM2COL_DMA_CH_NUM-1:0] ch_mask_i,
  input  logic [`IM2COL_DMA_CH_NUM-1:0] dma_done_i,
  input  logic                          ch_grab_i,
  input  logic                          ch_alloc_i,
  output logic                          ch_full_o,
  output logic [`IM2COL_CH_IDX_W-1:0]   cur_ch_o,
  output logic                          cur_ch_configured_o,
  output logic                          all_idle_o
);

  localparam int NCH = `IM2COL_DMA_CH_NUM;

  logic [NCH-1:0]               busy_q, cfg_q;
  logic [NCH-1:0]               alloc_vec;
  logic [`IM2COL_CH_IDX_W-1:0]  cur_ch_q, free_ch;
  logic                         any_free;

  // Scan downwards so the lowest free channel is the one that remains.
  always_comb begin
    free_ch  = '0;
    any_free = 1'b0;
    for (int i = NCH - 1; i >= 0; i--) begin
      if (!busy_q[i] && ch_mask_i[i]) begin
        free_ch  = i[`IM2COL_CH_IDX_W-1:0];
        any_free = 1'b1;
      end
    end
  end

  always_comb begin
    alloc_vec           = '0;
    alloc_vec[cur_ch_q] = ch_alloc_i;  // One-hot mark of the channel in load.
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q   <= '0;
      cfg_q    <= '0;
      cur_ch_q <= '0;
    end else if (start_i) begin
      busy_q   <= '0;  // New run, every channel unconfigured.
      cfg_q    <= '0;
      cur_ch_q <= '0;
    end else begin
      busy_q <= (busy_q & ~dma_done_i) | alloc_vec;
      cfg_q  <= cfg_q | alloc_vec;
      if (ch_grab_i) begin
        cur_ch_q <= free_ch;
      end
    end
  end

  assign ch_full_o           = !any_free;
  assign cur_ch_o            = cur_ch_q;
  assign cur_ch_configured_o = cfg_q[cur_ch_q];
  assign all_idle_o          = ~|busy_q;

  // The grabbed channel must still be free and enabled when the load starts.
  a_alloc_free: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ch_alloc_i |-> !busy_q[cur_ch_q] && ch_mask_i[cur_ch_q])
    else $error("allocation of busy or masked channel %0d", cur_ch_q);

endmodule

//--- im2col_ctrl.sv
// im2col run control: busy status, completion detection and interrupt flag.
module im2col_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic start_i,
  input  logic last_loaded_i,
  input  logic all_idle_i,
  input  logic irq_en_i,
  input  logic irq_clear_i,
  output logic run_done_pending_o,
  output logic busy_o,
  output logic irq_o
);

  logic busy_q;
  logic done_flag_q;  // Last transaction handed to a channel.
  logic run_done_q;
  logic irq_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q      <= 1'b0;
      done_flag_q <= 1'b0;
      run_done_q  <= 1'b0;
      irq_q       <= 1'b0;
    end else begin
      // Single pulse once the tail has drained from every channel.
      run_done_q <= done_flag_q && all_idle_i && !run_done_q;

      if (run_done_q || start_i) begin
        done_flag_q <= 1'b0;
      end else if (last_loaded_i) begin
        done_flag_q <= 1'b1;
      end

      if (run_done_q) begin
        busy_q <= 1'b0;
      end else if (start_i) begin
        busy_q <= 1'b1;
      end

      if (run_done_q && irq_en_i) begin
        irq_q <= 1'b1;
      end else if (irq_clear_i) begin
        irq_q <= 1'b0;
      end
    end
  end

  assign run_done_pending_o = done_flag_q;
  assign busy_o             = busy_q;
  assign irq_o              = irq_q;

endmodule

//--- im2col_dma_loader.sv
// DMA loader: dispatch and register-load FSMs that program one channel per transaction.
`include "im2col_settings.svh"

module im2col_dma_loader
  import im2col_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  trans_t                      head_i,
  input  logic                        fifo_empty_i,
  output logic                        fifo_pop_o,
  input  logic                        ch_full_i,
  input  logic [`IM2COL_CH_IDX_W-1:0] cur_ch_i,
  input  logic                        cur_ch_configured_i,
  output logic                        ch_grab_o,
  output logic                        ch_alloc_o,
  input  logic                        run_done_pending_i,
  input  data_type_t                  data_type_i,
  input  logic [3:0]                  log_stride_d1_i,
  input  logic [15:0]                 tx_slot_i,
  input  logic [15:0]                 rx_slot_i,
  output logic                        wr_req_o,
  output logic [31:0]                 wr_addr_o,
  output logic [31:0]                 wr_data_o,
  input  logic                        wr_done_i,
  output logic                        last_loaded_o
);

  disp_state_e disp_q, disp_d;
  load_state_e load_q, load_d;
  logic [31:0] reg_ofs;
  logic [31:0] ch_base;
  logic [1:0]  type_shift;

  always_comb begin
    disp_d = disp_q;
    unique case (disp_q)
      DISP_IDLE: begin
        if (!fifo_empty_i && !run_done_pending_i && !ch_full_i) begin
          disp_d = DISP_GET;
        end
      end
      DISP_GET: begin
        disp_d = fifo_empty_i ? DISP_IDLE : DISP_LOAD;
      end
      DISP_LOAD: begin
        if (load_q == LD_DONE) begin
          disp_d = (!ch_full_i && !head_i.last) ? DISP_GET : DISP_IDLE;
        end
      end
      default: begin
        disp_d = DISP_IDLE;
      end
    endcase
  end

  always_comb begin
    load_d = load_q;
    unique case (load_q)
      LD_IDLE: begin
        if (disp_q == DISP_GET && !fifo_empty_i) begin
          load_d = cur_ch_configured_i ? WR_TOP_PAD : WR_DIM;  // Short form on reuse.
        end
      end
      LD_DONE: begin
        load_d = LD_IDLE;
      end
      default: begin
        if (wr_done_i) begin
          load_d = load_state_e'(load_q + 5'd1);  // Next register in sequence.
        end
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      disp_q <= DISP_IDLE;
      load_q <= LD_IDLE;
    end else begin
      disp_q <= disp_d;
      load_q <= load_d;
    end
  end

  assign ch_grab_o     = (disp_d == DISP_GET) && (disp_q != DISP_GET);
  assign ch_alloc_o    = (disp_q == DISP_GET) && !fifo_empty_i;
  assign fifo_pop_o    = (load_q == LD_DONE);
  assign last_loaded_o = (load_q == LD_DONE) && head_i.last;
  assign wr_req_o      = (load_q != LD_IDLE) && (load_q != LD_DONE);

  assign type_shift = 2'd2 - data_type_i;  // Bytes per element as a shift.
  assign ch_base    = `IM2COL_DMA_BASE + 32'(cur_ch_i) * `IM2COL_DMA_CH_SIZE;
  assign wr_addr_o  = ch_base + reg_ofs;

  always_comb begin
    reg_ofs   = '0;
    wr_data_o = '0;
    case (load_q)
      WR_DIM: begin
        reg_ofs   = `IM2COL_OFS_DIM;
        wr_data_o = 32'd1;  // 1D transfers with padding.
      end
      WR_SLOTS: begin
        reg_ofs   = `IM2COL_OFS_SLOTS;
        wr_data_o = {tx_slot_i, rx_slot_i};
      end
      WR_SRC_TYPE: begin
        reg_ofs   = `IM2COL_OFS_SRC_TYPE;
        wr_data_o = {30'd0, data_type_i};
      end
      WR_DST_TYPE: begin
        reg_ofs   = `IM2COL_OFS_DST_TYPE;
        wr_data_o = {30'd0, data_type_i};
      end
      WR_TOP_PAD: begin
        reg_ofs   = `IM2COL_OFS_TOP_PAD;
        wr_data_o = {24'd0, head_i.pad_top};
      end
      WR_BOTTOM_PAD: begin
        reg_ofs   = `IM2COL_OFS_BOTTOM_PAD;
        wr_data_o = {24'd0, head_i.pad_bottom};
      end
      WR_LEFT_PAD: begin
        reg_ofs   = `IM2COL_OFS_LEFT_PAD;
        wr_data_o = {24'd0, head_i.pad_left};
      end
      WR_RIGHT_PAD: begin
        reg_ofs   = `IM2COL_OFS_RIGHT_PAD;
        wr_data_o = {24'd0, head_i.pad_right};
      end
      WR_IN_PTR: begin
        reg_ofs   = `IM2COL_OFS_SRC_PTR;
        wr_data_o = head_i.in_ptr;
      end
      WR_OUT_PTR: begin
        reg_ofs   = `IM2COL_OFS_DST_PTR;
        wr_data_o = head_i.out_ptr;
      end
      WR_INC_SRC_D1: begin
        reg_ofs   = `IM2COL_OFS_INC_SRC_D1;
        wr_data_o = ((32'd1 << log_stride_d1_i) << type_shift) & 32'h3f;  // 6-bit field.
      end
      WR_INC_SRC_D2: begin
        reg_ofs   = `IM2COL_OFS_INC_SRC_D2;
        wr_data_o = ({9'd0, head_i.src_inc_d2} << type_shift) & 32'h7f_ffff;
      end
      WR_INC_DST_D1: begin
        reg_ofs   = `IM2COL_OFS_INC_DST_D1;
        wr_data_o = 32'd4 >> data_type_i;  // Dense output, one element step.
      end
      WR_INC_DST_D2: begin
        reg_ofs   = `IM2COL_OFS_INC_DST_D2;
        wr_data_o = 32'd4 >> data_type_i;
      end
      WR_SIZE_D2: begin
        reg_ofs   = `IM2COL_OFS_SIZE_D2;
        wr_data_o = {16'd0, head_i.size_d2};
      end
      WR_SIZE_D1: begin
        reg_ofs   = `IM2COL_OFS_SIZE_D1;
        wr_data_o = {16'd0, head_i.size_d1};  // Triggers the channel.
      end
      default: begin
        reg_ofs   = '0;
        wr_data_o = '0;
      end
    endcase
  end

  // A pending write keeps its request, address and data until acknowledged.
  a_wr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wr_req_o && !wr_done_i |=> wr_req_o && $stable(wr_addr_o) && $stable(wr_data_o))
    else $error("DMA register write changed before its acknowledge");

endmodule

//--- im2col_pkg.sv
// im2col controller types: transaction record, FSM states and DMA data types.
package im2col_pkg;

  typedef struct packed {
    logic [7:0]  pad_top;
    logic [7:0]  pad_bottom;
    logic [7:0]  pad_left;
    logic [7:0]  pad_right;
    logic [31:0] in_ptr;
    logic [31:0] out_ptr;
    logic [22:0] src_inc_d2;  // In elements, scaled by the data type.
    logic [15:0] size_d1;
    logic [15:0] size_d2;
    logic        last;        // Final transaction of a run.
  } trans_t;

  typedef enum logic [1:0] {
    DISP_IDLE,
    DISP_GET,
    DISP_LOAD
  } disp_state_e;

  // Write states in bus order, so the next write is the following encoding.
  typedef enum logic [4:0] {
    LD_IDLE,
    WR_DIM, WR_SLOTS, WR_SRC_TYPE, WR_DST_TYPE,
    WR_TOP_PAD, WR_BOTTOM_PAD, WR_LEFT_PAD, WR_RIGHT_PAD,
    WR_IN_PTR, WR_OUT_PTR, WR_INC_SRC_D1, WR_INC_SRC_D2,
    WR_INC_DST_D1, WR_INC_DST_D2, WR_SIZE_D2, WR_SIZE_D1,
    LD_DONE
  } load_state_e;

  typedef enum logic [1:0] {
    DT_WORD = 2'd0,
    DT_HALF = 2'd1,
    DT_BYTE = 2'd2
  } data_type_t;

endpackage

//--- im2col_settings.svh
// im2col controller settings: DMA channel count, FIFO depth and DMA register map.
`ifndef IM2COL_SETTINGS_SVH
`define IM2COL_SETTINGS_SVH

`define IM2COL_DMA_CH_NUM   4             // Channels in the DMA.
`define IM2COL_CH_IDX_W     2             // Bits of a channel index.
`define IM2COL_FIFO_DEPTH   4             // Transaction FIFO entries.
`define IM2COL_DMA_BASE     32'h0006_0000 // DMA register space.
`define IM2COL_DMA_CH_SIZE  32'h100       // Stride between channel blocks.

`define IM2COL_OFS_SRC_PTR     32'h00
`define IM2COL_OFS_DST_PTR     32'h04
`define IM2COL_OFS_SIZE_D1     32'h0C
`define IM2COL_OFS_SIZE_D2     32'h10
`define IM2COL_OFS_INC_SRC_D1  32'h18
`define IM2COL_OFS_INC_SRC_D2  32'h1C
`define IM2COL_OFS_INC_DST_D1  32'h20
`define IM2COL_OFS_INC_DST_D2  32'h24
`define IM2COL_OFS_SLOTS       32'h28 // Tx slot in the upper half.
`define IM2COL_OFS_SRC_TYPE    32'h2C
`define IM2COL_OFS_DST_TYPE    32'h30
`define IM2COL_OFS_DIM         32'h3C
`define IM2COL_OFS_TOP_PAD     32'h44
`define IM2COL_OFS_BOTTOM_PAD  32'h48
`define IM2COL_OFS_RIGHT_PAD   32'h4C
`define IM2COL_OFS_LEFT_PAD    32'h50

`endif

//--- im2col_spc.f
+incdir+.
im2col_pkg.sv
im2col_trans_fifo.sv
im2col_ch_tracker.sv
im2col_dma_loader.sv
im2col_ctrl.sv
im2col_spc.sv
tb_im2col_spc.sv

//--- im2col_spc.sv
// im2col smart-peripheral controller top: FIFO, channel tracker, DMA loader, run control.
`include "im2col_settings.svh"

module im2col_spc
  import im2col_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          trans_push_i,
  input  trans_t                        trans_i,
  output logic                          trans_full_o,
  input  data_type_t                    data_type_i,
  input  logic [3:0]                    log_stride_d1_i,
  input  logic [15:0]                   tx_slot_i,
  input  logic [15:0]                   rx_slot_i,
  input  logic [`IM2COL_DMA_CH_NUM-1:0] ch_mask_i,
  input  logic                          start_i,
  input  logic                          irq_en_i,
  input  logic                          irq_clear_i,
  output logic                          wr_req_o,
  output logic [31:0]                   wr_addr_o,
  output logic [31:0]                   wr_data_o,
  input  logic                          wr_done_i,
  input  logic [`IM2COL_DMA_CH_NUM-1:0] dma_done_i,
  output logic                          busy_o,
  output logic                          irq_o
);

  trans_t                       head;
  logic                         fifo_empty, fifo_pop;
  logic                         ch_full, cur_ch_configured, all_idle;
  logic [`IM2COL_CH_IDX_W-1:0]  cur_ch;
  logic                         ch_grab, ch_alloc;
  logic                         last_loaded, run_done_pending;

  im2col_trans_fifo #(
    .DEPTH(`IM2COL_FIFO_DEPTH)
  ) u_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (trans_push_i),
    .data_i  (trans_i),
    .pop_i   (fifo_pop),
    .data_o  (head),
    .full_o  (trans_full_o),
    .empty_o (fifo_empty)
  );

  im2col_ch_tracker u_tracker (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .start_i             (start_i),
    .ch_mask_i           (ch_mask_i),
    .dma_done_i          (dma_done_i),
    .ch_grab_i           (ch_grab),
    .ch_alloc_i          (ch_alloc),
    .ch_full_o           (ch_full),
    .cur_ch_o            (cur_ch),
    .cur_ch_configured_o (cur_ch_configured),
    .all_idle_o          (all_idle)
  );

  im2col_dma_loader u_loader (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .head_i              (head),
    .fifo_empty_i        (fifo_empty),
    .fifo_pop_o          (fifo_pop),
    .ch_full_i           (ch_full),
    .cur_ch_i            (cur_ch),
    .cur_ch_configured_i (cur_ch_configured),
    .ch_grab_o           (ch_grab),
    .ch_alloc_o          (ch_alloc),
    .run_done_pending_i  (run_done_pending),
    .data_type_i         (data_type_i),
    .log_stride_d1_i     (log_stride_d1_i),
    .tx_slot_i           (tx_slot_i),
    .rx_slot_i           (rx_slot_i),
    .wr_req_o            (wr_req_o),
    .wr_addr_o           (wr_addr_o),
    .wr_data_o           (wr_data_o),
    .wr_done_i           (wr_done_i),
    .last_loaded_o       (last_loaded)
  );

  im2col_ctrl u_ctrl (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .start_i            (start_i),
    .last_loaded_i      (last_loaded),
    .all_idle_i         (all_idle),
    .irq_en_i           (irq_en_i),
    .irq_clear_i        (irq_clear_i),
    .run_done_pending_o (run_done_pending),
    .busy_o             (busy_o),
    .irq_o              (irq_o)
  );

endmodule

//--- im2col_trans_fifo.sv
// Transaction FIFO: fall-through circular buffer with full and empty flags.
`include "im2col_settings.svh"

module im2col_trans_fifo
  import im2col_pkg::*;
#(
  parameter int unsigned DEPTH = `IM2COL_FIFO_DEPTH
) (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   push_i,
  input  trans_t data_i,
  input  logic   pop_i,
  output trans_t data_o,
  output logic   full_o,
  output logic   empty_o
);

  localparam int unsigned AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CW = $clog2(DEPTH + 1);

  trans_t         mem_q [DEPTH];
  logic [AW-1:0]  wr_ptr_q, rd_ptr_q;
  logic [CW-1:0]  count_q;
  logic           wr_en, rd_en;

  assign full_o  = (count_q == CW'(DEPTH));
  assign empty_o = (count_q == '0);
  assign wr_en   = push_i && !full_o;
  assign rd_en   = pop_i && !empty_o;
  assign data_o  = mem_q[rd_ptr_q];  // Head visible without a pop.

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= (wr_ptr_q == AW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (rd_en) begin
        rd_ptr_q <= (rd_ptr_q == AW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CW'(wr_en) - CW'(rd_en);
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> !full_o) else $error("push into full transaction FIFO");
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> !empty_o) else $error("pop from empty transaction FIFO");

endmodule

//--- tb_im2col_spc.sv
// im2col controller testbench with a DMA register-port model, random runs and assertion checks.
`include "im2col_settings.svh"

module tb_im2col_spc
  import im2col_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [31:0] SEED = 32'hba05_e261;
  localparam int NCH = `IM2COL_DMA_CH_NUM;
  localparam int NUM_TRANS = 6;                          // Per run.
  localparam int WATCHDOG_NS = 12 * 16 * 6 * 40 + 20000;  // Worst-case loads plus margin.

  logic                 clk_i = 1'b0;
  logic                 rst_ni;
  logic                 trans_push_i;
  trans_t               trans_i;
  logic                 trans_full_o;
  data_type_t           data_type_i;
  logic [3:0]           log_stride_d1_i;
  logic [15:0]          tx_slot_i, rx_slot_i;
  logic [NCH-1:0]       ch_mask_i;
  logic                 start_i, irq_en_i, irq_clear_i;
  logic                 wr_req_o;
  logic [31:0]          wr_addr_o, wr_data_o;
  logic                 wr_done_i = 1'b0;
  logic [NCH-1:0]       dma_done_i = '0;
  logic                 busy_o, irq_o;

  trans_t               ref_q [$];   // Pushed and not yet seen on the write port.
  trans_t               cur_t;
  int                   pushed_cnt;
  int                   done_cnt = 0;
  int                   chk_errors = 0;
  int                   prop_errors = 0;
  int                   end_errors;
  logic [31:0]          stim_rng;
  logic [31:0]          dma_rng = SEED;
  logic [NCH-1:0]       cfg_m = '0;  // Channels programmed since start.
  logic [NCH-1:0]       ch_busy_m = '0;
  int                   done_timer [NCH] = '{default: 0};
  logic                 in_trans = 1'b0;
  logic                 pending = 1'b0;
  int                   step = 0;
  int                   cur_ch = 0;
  int                   wait_cnt = 0;
  int                   fifo_occ = 0;     // Entries the DUT FIFO should hold.
  logic                 d1_acked = 1'b0;  // Size-D1 write acknowledged in this cycle.
  logic                 pop_next = 1'b0;  // Head leaves the FIFO on the coming edge.

  im2col_spc im2col_spc_inst (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .trans_push_i    (trans_push_i),
    .trans_i         (trans_i),
    .trans_full_o    (trans_full_o),
    .data_type_i     (data_type_i),
    .log_stride_d1_i (log_stride_d1_i),
    .tx_slot_i       (tx_slot_i),
    .rx_slot_i       (rx_slot_i),
    .ch_mask_i       (ch_mask_i),
    .start_i         (start_i),
    .irq_en_i        (irq_en_i),
    .irq_clear_i     (irq_clear_i),
    .wr_req_o        (wr_req_o),
    .wr_addr_o       (wr_addr_o),
    .wr_data_o       (wr_data_o),
    .wr_done_i       (wr_done_i),
    .dma_done_i      (dma_done_i),
    .busy_o          (busy_o),
    .irq_o           (irq_o)
  );

  always #20 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Register offsets in bus order. Step 4 is where a configured channel starts.
  function automatic logic [31:0] reg_offset(input int idx);
    case (idx)
      0:       return `IM2COL_OFS_DIM;
      1:       return `IM2COL_OFS_SLOTS;
      2:       return `IM2COL_OFS_SRC_TYPE;
      3:       return `IM2COL_OFS_DST_TYPE;
      4:       return `IM2COL_OFS_TOP_PAD;
      5:       return `IM2COL_OFS_BOTTOM_PAD;
      6:       return `IM2COL_OFS_LEFT_PAD;
      7:       return `IM2COL_OFS_RIGHT_PAD;
      8:       return `IM2COL_OFS_SRC_PTR;
      9:       return `IM2COL_OFS_DST_PTR;
      10:      return `IM2COL_OFS_INC_SRC_D1;
      11:      return `IM2COL_OFS_INC_SRC_D2;
      12:      return `IM2COL_OFS_INC_DST_D1;
      13:      return `IM2COL_OFS_INC_DST_D2;
      14:      return `IM2COL_OFS_SIZE_D2;
      default: return `IM2COL_OFS_SIZE_D1;
    endcase
  endfunction

  function automatic logic [31:0] expected_data(input int idx, input trans_t t);
    int sh;
    sh = 2 - int'(data_type_i);  // Bytes per element as a shift.
    case (idx)
      0:       return 32'd1;
      1:       return {tx_slot_i, rx_slot_i};
      2, 3:    return {30'd0, data_type_i};
      4:       return {24'd0, t.pad_top};
      5:       return {24'd0, t.pad_bottom};
      6:       return {24'd0, t.pad_left};
      7:       return {24'd0, t.pad_right};
      8:       return t.in_ptr;
      9:       return t.out_ptr;
      10:      return ((32'd1 << log_stride_d1_i) << sh) & 32'h3f;
      11:      return ({9'd0, t.src_inc_d2} << sh) & 32'h7f_ffff;
      12, 13:  return 32'd4 >> data_type_i;
      14:      return {16'd0, t.size_d2};
      default: return {16'd0, t.size_d1};
    endcase
  endfunction

  function automatic trans_t make_trans(input logic last);
    trans_t t;
    stim_rng     = xorshift(stim_rng);
    t.pad_top    = {5'd0, stim_rng[2:0]};
    t.pad_bottom = {5'd0, stim_rng[5:3]};
    t.pad_left   = {5'd0, stim_rng[8:6]};
    t.pad_right  = {5'd0, stim_rng[11:9]};
    t.size_d1    = stim_rng[27:12];
    stim_rng     = xorshift(stim_rng);
    t.in_ptr     = stim_rng;
    stim_rng     = xorshift(stim_rng);
    t.out_ptr    = stim_rng;
    stim_rng     = xorshift(stim_rng);
    t.src_inc_d2 = stim_rng[22:0];
    t.size_d2    = {8'd0, stim_rng[30:23]};
    t.last       = last;
    return t;
  endfunction

  // Checks the write that is acknowledged in this cycle.
  task automatic check_write();
    logic [31:0] ch_rel;
    logic [31:0] exp_addr;
    logic [31:0] exp_data;
    if (!in_trans) begin
      ch_rel = (wr_addr_o - `IM2COL_DMA_BASE) / `IM2COL_DMA_CH_SIZE;
      cur_ch = int'(ch_rel % NCH);
      assert (ch_rel < NCH && ch_mask_i[cur_ch] && !ch_busy_m[cur_ch]) else begin
        chk_errors++;
        $display("Load started on channel %0d, which is masked, busy or out of range", ch_rel);
      end
      assert (ref_q.size() > 0) else begin
        chk_errors++;
        $display("DMA load started with no transaction pushed");
      end
      if (ref_q.size() > 0) begin
        cur_t = ref_q.pop_front();  // Push order.
      end
      step           = cfg_m[cur_ch] ? 4 : 0;
      cfg_m[cur_ch]  = 1'b1;
      in_trans       = 1'b1;
    end
    exp_addr = `IM2COL_DMA_BASE + 32'(cur_ch) * `IM2COL_DMA_CH_SIZE + reg_offset(step);
    exp_data = expected_data(step, cur_t);
    assert (wr_addr_o == exp_addr) else begin
      chk_errors++;
      $display("[FAIL] write %0d address: expected %h, actual %h", step, exp_addr, wr_addr_o);
    end
    assert (wr_data_o == exp_data) else begin
      chk_errors++;
      $display("[FAIL] write %0d data: expected %h, actual %h", step, exp_data, wr_data_o);
    end
    if (step == 15) begin
      in_trans           = 1'b0;
      d1_acked           = 1'b1;
      ch_busy_m[cur_ch]  = 1'b1;
      dma_rng            = xorshift(dma_rng);
      done_timer[cur_ch] = 2 + int'(dma_rng[2:0]);  // Channel runs 2 to 9 cycles.
    end else begin
      step++;
    end
  endtask

  // DMA model with register-port acknowledge and per-channel done pulses.
  always @(negedge clk_i) begin
    wr_done_i  = 1'b0;
    dma_done_i = '0;
    d1_acked   = 1'b0;
    if (!busy_o) begin
      cfg_m = '0;  // Start clears the configured bits.
    end
    for (int c = 0; c < NCH; c++) begin
      if (done_timer[c] > 0) begin
        done_timer[c]--;
        if (done_timer[c] == 0) begin
          dma_done_i[c] = 1'b1;
          ch_busy_m[c]  = 1'b0;
          done_cnt++;
        end
      end
    end
    if (rst_ni && wr_req_o) begin
      if (!pending) begin
        dma_rng  = xorshift(dma_rng);
        wait_cnt = int'(dma_rng[1:0]);  // Acknowledge after 0 to 3 cycles.
        pending  = 1'b1;
      end
      if (wait_cnt == 0) begin
        check_write();
        wr_done_i = 1'b1;
        pending   = 1'b0;
      end else begin
        wait_cnt--;
      end
    end
  end

  // FIFO occupancy. DONE follows the size-D1 acknowledge and pops on the next edge.
  always @(posedge clk_i) begin
    pop_next <= d1_acked;
    fifo_occ <= fifo_occ + int'(trans_push_i) - int'(pop_next);
  end

  a_reset_quiet: assert property (@(posedge clk_i)
    !rst_ni |-> !wr_req_o && !busy_o && !irq_o && !trans_full_o)
    else begin
      prop_errors++;
      $display("DUT outputs were not idle during reset");
    end

  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    trans_push_i |-> fifo_occ < `IM2COL_FIFO_DEPTH)
    else begin
      prop_errors++;
      $display("Transaction pushed while the FIFO was full");
    end

  a_full_flag: assert property (@(posedge clk_i) disable iff (!rst_ni)
    trans_full_o == (fifo_occ == `IM2COL_FIFO_DEPTH))
    else begin
      prop_errors++;
      $display("[FAIL] FIFO full flag: expected %0b, actual %0b",
               $sampled(fifo_occ) == `IM2COL_FIFO_DEPTH, $sampled(trans_full_o));
    end

  a_start_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    start_i |=> busy_o)
    else begin
      prop_errors++;
      $display("busy_o did not rise after start");
    end

  a_busy_drained: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(busy_o) |-> pushed_cnt == done_cnt)
    else begin
      prop_errors++;
      $display("busy_o fell before every transaction was loaded and done");
    end

  a_irq_enable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(busy_o) |-> irq_o == irq_en_i)
    else begin
      prop_errors++;
      $display("[FAIL] irq at completion: expected %0b, actual %0b",
               $sampled(irq_en_i), $sampled(irq_o));
    end

  a_irq_source: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(irq_o) |-> $fell(busy_o))
    else begin
      prop_errors++;
      $display("irq_o rose without a run completing");
    end

  a_irq_clear: assert property (@(posedge clk_i) disable iff (!rst_ni)
    irq_clear_i |=> !irq_o)
    else begin
      prop_errors++;
      $display("irq_o stayed high after irq_clear_i");
    end

  task automatic run_batch(input logic irq_en, input data_type_t dt, input logic [3:0] stride,
                           input logic [15:0] tx, input logic [15:0] rx);
    int gap;
    irq_en_i        = irq_en;
    data_type_i     = dt;
    log_stride_d1_i = stride;
    tx_slot_i       = tx;
    rx_slot_i       = rx;
    start_i         = 1'b1;
    @(negedge clk_i);
    start_i = 1'b0;
    for (int n = 0; n < NUM_TRANS; n++) begin
      stim_rng     = xorshift(stim_rng);
      gap          = (n < 4) ? 0 : int'(stim_rng[2:0]);  // Opening burst fills the FIFO.
      trans_push_i = 1'b0;
      repeat (gap) @(negedge clk_i);
      while (trans_full_o) begin
        @(negedge clk_i);
      end
      trans_i      = make_trans(n == NUM_TRANS - 1);
      trans_push_i = 1'b1;
      ref_q.push_back(trans_i);
      pushed_cnt++;
      @(negedge clk_i);
    end
    trans_push_i = 1'b0;
    while (busy_o) begin
      @(negedge clk_i);
    end
    repeat (3) @(negedge clk_i);
    irq_clear_i = 1'b1;
    @(negedge clk_i);
    irq_clear_i = 1'b0;
    repeat (2) @(negedge clk_i);
  endtask

  initial begin
    int total;
    rst_ni          = 1'b1;
    trans_push_i    = 1'b0;
    trans_i         = '0;
    data_type_i     = DT_WORD;
    log_stride_d1_i = '0;
    tx_slot_i       = '0;
    rx_slot_i       = '0;
    ch_mask_i       = 4'b1011;  // Channel 2 left out.
    start_i         = 1'b0;
    irq_en_i        = 1'b0;
    irq_clear_i     = 1'b0;
    stim_rng        = SEED;
    pushed_cnt      = 0;
    end_errors      = 0;
    #1 rst_ni = 1'b0;
    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;
    repeat (2) @(negedge clk_i);
    run_batch(1'b1, DT_HALF, 4'd2, 16'h0003, 16'h0005);
    run_batch(1'b0, DT_BYTE, 4'd1, 16'h0011, 16'h0012);
    assert (ref_q.size() == 0 && pushed_cnt == done_cnt) else begin
      end_errors++;
      $display("Not every pushed transaction was loaded and completed");
    end
    total = chk_errors + prop_errors + end_errors;
    $display("Errors: %0d write checks, %0d properties, %0d end of test",
             chk_errors, prop_errors, end_errors);
    if (total == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout after %0d ns, the DUT stopped making progress", WATCHDOG_NS);
    $display("Verification failed");
    $finish;
  end

endmodule
